// ==== Makefile ====
# Verilator build and run of the riscv_core testbench

SRCS := $(shell cat build.f)

obj_dir/Vtb_riscv_core: build.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_riscv_core -f build.f

sim.log: obj_dir/Vtb_riscv_core
	./obj_dir/Vtb_riscv_core +verilator+error+limit+1000 > sim.log 2>&1 || true

run: sim.log
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== build.f ====
logic/core_pkg.sv
logic/riscv_alu.sv
logic/riscv_register_file.sv
logic/riscv_decoder.sv
logic/riscv_if_stage.sv
logic/riscv_id_ex_stage.sv
logic/riscv_load_store_unit.sv
logic/riscv_core.sv
verification/tb_clock_gen.sv
verification/riscv_core_assert.sv
verification/tb_riscv_core.sv

// ==== logic/core_pkg.sv ====
// core_pkg
// shared widths, word types and encodings for the small RV32I integer core

package core_pkg;

  localparam int XLEN       = 32;  // data word width
  localparam int REG_ADDR_W = 5;   // 32 architectural registers

  typedef logic [XLEN-1:0]       word_t;      // data, address or instruction
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // register index

  //////////////////////////////////////////////////////////////////////
  // major opcodes, instr[6:0]
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  //////////////////////////////////////////////////////////////////////
  // alu operations
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_XOR    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_AND    = 3'd4,
    ALU_SLT    = 3'd5,  // signed compare, 0 or 1
    ALU_PASS_B = 3'd6   // lui, operand b straight through
  } alu_op_e;

endpackage

// ==== logic/riscv_alu.sv ====
// integer alu
// add, subtract, bitwise logic, signed set-less-than, pass b
`timescale 1ns/1ns

module riscv_alu
  import core_pkg::*;
(
  input  alu_op_e alu_op_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o
);

  logic lt_signed;

  assign lt_signed = $signed(operand_a_i) < $signed(operand_b_i);

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    result_o = operand_a_i + operand_b_i;
      ALU_SUB:    result_o = operand_a_i - operand_b_i;
      ALU_XOR:    result_o = operand_a_i ^ operand_b_i;
      ALU_OR:     result_o = operand_a_i | operand_b_i;
      ALU_AND:    result_o = operand_a_i & operand_b_i;
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_PASS_B: result_o = operand_b_i;   // lui
      default:    result_o = '0;
    endcase
  end

endmodule

// ==== logic/riscv_core.sv ====
// riscv_core
// small in-order rv32i core: fetch, decode/execute, load store unit
`timescale 1ns/1ns

module riscv_core
  import core_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  word_t boot_addr_i,
  input  logic  fetch_enable_i,
  output logic  core_busy_o,
  // instruction memory port
  output logic  instr_req_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  output word_t instr_addr_o,
  input  word_t instr_rdata_i,
  // data memory port
  output logic  data_req_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  output logic  data_we_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  input  word_t data_rdata_i
);

  logic  instr_valid, instr_ready;   // if -> id/ex
  word_t instr_rdata;
  logic  lsu_req, lsu_we, lsu_done;  // id/ex <-> lsu
  word_t lsu_addr, lsu_wdata, lsu_rdata;
  logic  if_busy, id_busy;

  assign core_busy_o = if_busy | id_busy;

  //////////////////////////////////////////////////////////////////////
  // fetch
  //////////////////////////////////////////////////////////////////////
  riscv_if_stage if_stage_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_valid_o  ( instr_valid    ),
    .instr_rdata_o  ( instr_rdata    ),
    .instr_ready_i  ( instr_ready    ),
    .if_busy_o      ( if_busy        )
  );

  //////////////////////////////////////////////////////////////////////
  // decode, execute, write-back
  //////////////////////////////////////////////////////////////////////
  riscv_id_ex_stage id_ex_stage_i (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .instr_valid_i ( instr_valid ),
    .instr_rdata_i ( instr_rdata ),
    .instr_ready_o ( instr_ready ),
    .lsu_req_o     ( lsu_req     ),
    .lsu_we_o      ( lsu_we      ),
    .lsu_addr_o    ( lsu_addr    ),
    .lsu_wdata_o   ( lsu_wdata   ),
    .lsu_done_i    ( lsu_done    ),
    .lsu_rdata_i   ( lsu_rdata   ),
    .id_busy_o     ( id_busy     )
  );

  riscv_load_store_unit load_store_unit_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .lsu_req_i     ( lsu_req       ),
    .lsu_we_i      ( lsu_we        ),
    .lsu_addr_i    ( lsu_addr      ),
    .lsu_wdata_i   ( lsu_wdata     ),
    .lsu_done_o    ( lsu_done      ),
    .lsu_rdata_o   ( lsu_rdata     ),
    .data_req_o    ( data_req_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_we_o     ( data_we_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .data_rdata_i  ( data_rdata_i  )
  );

endmodule

// ==== logic/riscv_decoder.sv ====
// instruction decoder
// opcode, funct3 and funct7 into alu, register write and memory controls
`timescale 1ns/1ns

module riscv_decoder
  import core_pkg::*;
(
  input  word_t     instr_i,
  output alu_op_e   alu_op_o,
  output logic      use_imm_o,   // operand b from imm_o
  output word_t     imm_o,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output reg_addr_t rd_o,
  output logic      rf_we_o,     // result goes to rd
  output logic      mem_req_o,
  output logic      mem_we_o     // store
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i_type, imm_s_type, imm_u_type;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];
  assign rd_o   = instr_i[11:7];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    alu_op_o  = ALU_ADD;      // also the address adder for loads and stores
    use_imm_o = 1'b1;
    imm_o     = imm_i_type;
    rf_we_o   = 1'b0;         // anything unmatched retires as a no-op
    mem_req_o = 1'b0;
    mem_we_o  = 1'b0;
    case (opcode)
      OPC_LUI: begin
        alu_op_o = ALU_PASS_B;
        imm_o    = imm_u_type;
        rf_we_o  = 1'b1;
      end
      OPC_OP_IMM: begin
        rf_we_o = 1'b1;
        case (funct3)
          3'b000:  alu_op_o = ALU_ADD;
          3'b010:  alu_op_o = ALU_SLT;
          3'b100:  alu_op_o = ALU_XOR;
          3'b110:  alu_op_o = ALU_OR;
          3'b111:  alu_op_o = ALU_AND;
          default: rf_we_o  = 1'b0;   // sltiu and shifts not kept
        endcase
      end
      OPC_OP: begin
        use_imm_o = 1'b0;
        rf_we_o   = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op_o = ALU_ADD;
          10'b0100000_000: alu_op_o = ALU_SUB;
          10'b0000000_010: alu_op_o = ALU_SLT;
          10'b0000000_100: alu_op_o = ALU_XOR;
          10'b0000000_110: alu_op_o = ALU_OR;
          10'b0000000_111: alu_op_o = ALU_AND;
          default:         rf_we_o  = 1'b0;
        endcase
      end
      OPC_LOAD: if (funct3 == 3'b010) begin   // lw only
        rf_we_o   = 1'b1;
        mem_req_o = 1'b1;
      end
      OPC_STORE: if (funct3 == 3'b010) begin  // sw only
        imm_o     = imm_s_type;
        mem_req_o = 1'b1;
        mem_we_o  = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== logic/riscv_id_ex_stage.sv ====
// decode, execute and write-back stage
// alu ops retire in the take cycle, loads and stores hold the stage until lsu done
`timescale 1ns/1ns

module riscv_id_ex_stage
  import core_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // from fetch
  input  logic  instr_valid_i,
  input  word_t instr_rdata_i,
  output logic  instr_ready_o,
  // to load store unit
  output logic  lsu_req_o,
  output logic  lsu_we_o,
  output word_t lsu_addr_o,
  output word_t lsu_wdata_o,
  input  logic  lsu_done_i,
  input  word_t lsu_rdata_i,
  output logic  id_busy_o
);

  alu_op_e   alu_op;
  logic      use_imm, rf_we, mem_req, mem_we;
  word_t     imm, rdata_a, rdata_b, alu_b, alu_result;
  reg_addr_t rs1, rs2, rd;

  logic      take;          // instruction accepted this cycle
  logic      pending_q;     // memory access in flight
  logic      lsu_we_q;
  word_t     lsu_addr_q, lsu_wdata_q;
  reg_addr_t load_rd_q;     // rd of the outstanding load

  logic      wb_we;
  reg_addr_t wb_addr;
  word_t     wb_data;

  riscv_decoder decoder_i (
    .instr_i   ( instr_rdata_i ),
    .alu_op_o  ( alu_op        ),
    .use_imm_o ( use_imm       ),
    .imm_o     ( imm           ),
    .rs1_o     ( rs1           ),
    .rs2_o     ( rs2           ),
    .rd_o      ( rd            ),
    .rf_we_o   ( rf_we         ),
    .mem_req_o ( mem_req       ),
    .mem_we_o  ( mem_we        )
  );

  riscv_register_file registers_i (
    .clk_i     ( clk_i   ),
    .rst_n_i   ( rst_n_i ),
    .raddr_a_i ( rs1     ),
    .raddr_b_i ( rs2     ),
    .waddr_i   ( wb_addr ),
    .we_i      ( wb_we   ),
    .wdata_i   ( wb_data ),
    .rdata_a_o ( rdata_a ),
    .rdata_b_o ( rdata_b )
  );

  assign alu_b = use_imm ? imm : rdata_b;

  riscv_alu alu_i (
    .alu_op_i    ( alu_op     ),
    .operand_a_i ( rdata_a    ),
    .operand_b_i ( alu_b      ),
    .result_o    ( alu_result )   // also the load/store address
  );

  // stalled for the whole access, done cycle included, so the write port is free
  assign instr_ready_o = ~pending_q;
  assign take          = instr_valid_i & instr_ready_o;

  ////////////////////////////////////////////////////////////////////
  // write-back: alu in the take cycle, load data in the done cycle
  ////////////////////////////////////////////////////////////////////
  assign wb_we   = (take & rf_we & ~mem_req) | (pending_q & lsu_done_i & ~lsu_we_q);
  assign wb_addr = pending_q ? load_rd_q : rd;
  assign wb_data = pending_q ? lsu_rdata_i : alu_result;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i)                 pending_q <= 1'b0;
    else if (take && mem_req)     pending_q <= 1'b1;
    else if (lsu_done_i)          pending_q <= 1'b0;
  end

  // request fields, held until lsu_done_i
  always_ff @(posedge clk_i) begin
    if (take && mem_req) begin
      lsu_we_q    <= mem_we;
      lsu_addr_q  <= alu_result;
      lsu_wdata_q <= rdata_b;    // rs2 for sw
      load_rd_q   <= rd;
    end
  end

  assign lsu_req_o   = pending_q;
  assign lsu_we_o    = lsu_we_q;
  assign lsu_addr_o  = lsu_addr_q;
  assign lsu_wdata_o = lsu_wdata_q;
  assign id_busy_o   = pending_q;

endmodule

// ==== logic/riscv_if_stage.sv ====
// instruction fetch
// one outstanding req/gnt/rvalid request, returned word parked in a one-entry buffer
`timescale 1ns/1ns

module riscv_if_stage
  import core_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  word_t boot_addr_i,     // static after reset
  input  logic  fetch_enable_i,
  // instruction memory port
  output logic  instr_req_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  output word_t instr_addr_o,
  input  word_t instr_rdata_i,
  // to id/ex
  output logic  instr_valid_o,
  output word_t instr_rdata_o,
  input  logic  instr_ready_i,
  output logic  if_busy_o
);

  typedef enum logic [1:0] {IF_IDLE, IF_REQ, IF_WAIT} if_state_e;

  if_state_e state_q, state_d;
  word_t     pc_q;          // address of the next fetch
  logic      boot_q;        // pc still waiting for boot_addr_i
  logic      buf_valid_q;
  word_t     buf_data_q;
  logic      take;          // id/ex empties the buffer this cycle

  assign take = buf_valid_q & instr_ready_i;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IF_IDLE: if (fetch_enable_i && (!buf_valid_q || take)) state_d = IF_REQ;
      IF_REQ:  if (instr_gnt_i)    state_d = IF_WAIT;  // hold req and addr until gnt
      IF_WAIT: if (instr_rvalid_i) state_d = IF_IDLE;
      default: state_d = IF_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IF_IDLE;
      pc_q        <= '0;
      boot_q      <= 1'b1;
      buf_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      boot_q  <= 1'b0;
      if (boot_q)                          pc_q <= boot_addr_i;  // first edge after reset
      else if (instr_req_o && instr_gnt_i) pc_q <= pc_q + 32'd4;  // straight-line only
      if (state_q == IF_WAIT && instr_rvalid_i) buf_valid_q <= 1'b1;
      else if (take)                            buf_valid_q <= 1'b0;
    end
  end

  // returned word
  always_ff @(posedge clk_i) begin
    if (state_q == IF_WAIT && instr_rvalid_i) buf_data_q <= instr_rdata_i;
  end

  assign instr_req_o   = (state_q == IF_REQ);
  assign instr_addr_o  = pc_q;
  assign instr_valid_o = buf_valid_q;
  assign instr_rdata_o = buf_data_q;
  assign if_busy_o     = (state_q != IF_IDLE) | buf_valid_q;  // in flight or parked

endmodule

// ==== logic/riscv_load_store_unit.sv ====
// load store unit
// one word access at a time on the req/gnt/rvalid data port
`timescale 1ns/1ns

module riscv_load_store_unit
  import core_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // from id/ex
  input  logic  lsu_req_i,
  input  logic  lsu_we_i,
  input  word_t lsu_addr_i,
  input  word_t lsu_wdata_i,
  output logic  lsu_done_o,
  output word_t lsu_rdata_o,
  // data memory port
  output logic  data_req_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  output logic  data_we_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  input  word_t data_rdata_i
);

  // idle, then request until gnt, then wait for rvalid
  typedef enum logic [1:0] {LS_IDLE, LS_REQ, LS_WAIT} ls_state_e;

  ls_state_e state_q;
  logic      we_q;
  word_t     addr_q, wdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LS_IDLE;
    end else begin
      case (state_q)
        LS_IDLE: if (lsu_req_i)     state_q <= LS_REQ;   // req still high in done cycle
        LS_REQ:  if (data_gnt_i)    state_q <= LS_WAIT;
        LS_WAIT: if (data_rvalid_i) state_q <= LS_IDLE;
        default:                    state_q <= LS_IDLE;
      endcase
    end
  end

  // captured once per access, stable through the gnt wait
  always_ff @(posedge clk_i) begin
    if (state_q == LS_IDLE && lsu_req_i) begin
      we_q    <= lsu_we_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
  end

  assign data_req_o   = (state_q == LS_REQ);
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  assign lsu_done_o  = (state_q == LS_WAIT) & data_rvalid_i;  // stores complete here too
  assign lsu_rdata_o = data_rdata_i;

endmodule

// ==== logic/riscv_register_file.sv ====
// integer register file
// x1..x31 in flip-flops, two read ports, one write port, x0 hard zero
`timescale 1ns/1ns

module riscv_register_file
  import core_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  reg_addr_t waddr_i,
  input  logic      we_i,
  input  word_t     wdata_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o
);

  word_t regs_q [1:31];  // no storage behind x0

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) regs_q[i] <= '0;
    end else if (we_i && waddr_i != '0) begin   // x0 writes dropped
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== verification/riscv_core_assert.sv ====
// riscv_core port protocol checks
// request fields hold until grant, nothing raised while in reset
`timescale 1ns/1ns

module riscv_core_assert
  import core_pkg::*;
(
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  core_busy_o,
  input logic  instr_req_o,
  input logic  instr_gnt_i,
  input word_t instr_addr_o,
  input logic  data_req_o,
  input logic  data_gnt_i,
  input logic  data_we_o,
  input word_t data_addr_o,
  input word_t data_wdata_o
);

  int fail_count = 0;   // picked up by the testbench at the end

  // requests and busy low while reset is applied
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !instr_req_o && !data_req_o && !core_busy_o)
    else begin
      $error("request or busy raised during reset");
      fail_count++;
    end

  ////////////////////////////////////////////////////////////////////
  // hold until grant
  ////////////////////////////////////////////////////////////////////
  instr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      $error("instruction request dropped or changed before grant");
      fail_count++;
    end

  data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
      && $stable(data_we_o) && $stable(data_wdata_o))
    else begin
      $error("data request dropped or changed before grant");
      fail_count++;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
// testbench clock and reset
// 40 ns clock, active-low reset held for 8 cycles
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;             // release away from the sampling edge
  end

  always #20 clk_o = ~clk_o;    // 40 ns period

endmodule

// ==== verification/tb_riscv_core.sv ====
// riscv_core testbench
// random straight-line program, memory responders with random delays, isa model
`timescale 1ns/1ns

module tb_riscv_core
  import core_pkg::*;
();

  localparam int    PROG_LEN  = 60;
  localparam int    BODY_LEN  = 29;              // random part after the lui of x1
  localparam word_t BOOT_ADDR = 32'h0000_0080;
  localparam word_t DATA_BASE = 32'h0002_0000;
  localparam int    DUMP_OFF  = 256;             // dump area, bytes above DATA_BASE
  localparam word_t NOP       = 32'h0000_0013;   // addi x0, x0, 0
  // instruction kinds, 0..11 are the alu ops
  localparam int K_LUI = 0, K_ADDI = 1, K_XORI = 2, K_ORI = 3, K_ANDI = 4, K_SLTI = 5;
  localparam int K_ADD = 6, K_SUB = 7, K_XOR = 8, K_OR = 9, K_AND = 10, K_SLT = 11;
  localparam int K_LW = 12, K_SW = 13;
  localparam int T_FETCH = 0, T_STORE = 1, T_LOAD = 2, T_REGS = 3, T_DONE = 4;

  int seed = 32'hc588_482b;

  logic  clk;
  logic  rst_n;
  word_t boot_addr    = BOOT_ADDR;
  logic  fetch_enable = 1'b0;
  logic  core_busy;
  logic  instr_req;
  logic  instr_gnt    = 1'b0;
  logic  instr_rvalid = 1'b0;
  word_t instr_addr;
  word_t instr_rdata  = '0;
  logic  data_req;
  logic  data_gnt     = 1'b0;
  logic  data_rvalid  = 1'b0;
  logic  data_we;
  word_t data_addr;
  word_t data_wdata;
  word_t data_rdata   = '0;

  // program fields and encodings
  int          kind [PROG_LEN];
  reg_addr_t   rd   [PROG_LEN];
  reg_addr_t   rs1  [PROG_LEN];
  reg_addr_t   rs2  [PROG_LEN];
  logic [19:0] imm  [PROG_LEN];   // low 12 bits for i and s types
  word_t       prog [PROG_LEN];

  word_t dmem [word_t];          // what the core wrote
  word_t model_mem [word_t];
  word_t model_regs [32];
  word_t exp_st_addr [$];
  word_t exp_st_data [$];
  word_t exp_ld_addr [$];
  int    n_stores;
  int    store_count = 0;
  int    checks [5] = '{default: 0};
  int    errs   [5] = '{default: 0};
  logic  timed_out  = 1'b0;

  tb_clock_gen clock_gen_i (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  riscv_core u_riscv_core (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .boot_addr_i    ( boot_addr    ),
    .fetch_enable_i ( fetch_enable ),
    .core_busy_o    ( core_busy    ),
    .instr_req_o    ( instr_req    ),
    .instr_gnt_i    ( instr_gnt    ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_addr_o   ( instr_addr   ),
    .instr_rdata_i  ( instr_rdata  ),
    .data_req_o     ( data_req     ),
    .data_gnt_i     ( data_gnt     ),
    .data_rvalid_i  ( data_rvalid  ),
    .data_we_o      ( data_we      ),
    .data_addr_o    ( data_addr    ),
    .data_wdata_o   ( data_wdata   ),
    .data_rdata_i   ( data_rdata   )
  );

  bind riscv_core riscv_core_assert core_assert_i (.*);

  function automatic int urand(input int n);
    urand = int'($unsigned($random(seed)) % n);
  endfunction

  // unwritten data words, every address bit matters
  function automatic word_t fill_word(input word_t a);
    fill_word = {a[15:0], a[31:16]} ^ 32'ha5a5_5a5a;
  endfunction

  function automatic word_t mem_read(input word_t a);
    mem_read = dmem.exists(a) ? dmem[a] : fill_word(a);
  endfunction

  function automatic word_t model_read(input word_t a);
    model_read = model_mem.exists(a) ? model_mem[a] : fill_word(a);
  endfunction

  function automatic word_t imem_read(input word_t a);
    int idx;
    idx = int'((a - BOOT_ADDR) >> 2);
    imem_read = (a >= BOOT_ADDR && idx < PROG_LEN) ? prog[idx] : NOP;  // no-ops past the end
  endfunction

  // rv32i encodings of the kept instructions
  function automatic word_t encode(input int k, input reg_addr_t d, s1, s2,
                                   input logic [19:0] im);
    case (k)
      K_LUI:   encode = {im, d, 7'b0110111};
      K_ADDI:  encode = {im[11:0], s1, 3'b000, d, 7'b0010011};
      K_XORI:  encode = {im[11:0], s1, 3'b100, d, 7'b0010011};
      K_ORI:   encode = {im[11:0], s1, 3'b110, d, 7'b0010011};
      K_ANDI:  encode = {im[11:0], s1, 3'b111, d, 7'b0010011};
      K_SLTI:  encode = {im[11:0], s1, 3'b010, d, 7'b0010011};
      K_ADD:   encode = {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
      K_SUB:   encode = {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
      K_XOR:   encode = {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
      K_OR:    encode = {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
      K_AND:   encode = {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
      K_SLT:   encode = {7'b0000000, s2, s1, 3'b010, d, 7'b0110011};
      K_LW:    encode = {im[11:0], s1, 3'b010, d, 7'b0000011};
      default: encode = {im[11:5], s2, s1, 3'b010, im[4:0], 7'b0100011};  // sw
    endcase
  endfunction

  task automatic gen_program();
    int k;
    kind[0] = K_LUI;                               // x1 = data base, never rewritten
    rd[0]   = 5'd1;
    rs1[0]  = 5'd0;
    rs2[0]  = 5'd0;
    imm[0]  = DATA_BASE[31:12];
    for (int i = 1; i <= BODY_LEN; i++) begin
      k       = urand(16);
      kind[i] = (k < 12) ? k : ((k < 14) ? K_LW : K_SW);
      rd[i]   = reg_addr_t'(2 + urand(30));
      rs1[i]  = (kind[i] >= K_LW) ? 5'd1 : reg_addr_t'(urand(32));
      rs2[i]  = reg_addr_t'(urand(32));
      imm[i]  = (kind[i] >= K_LW) ? 20'(urand(16) * 4) : 20'(urand(1 << 20));
    end
    for (int r = 2; r < 32; r++) begin             // dump x2..x31
      kind[BODY_LEN + r - 1] = K_SW;
      rd[BODY_LEN + r - 1]   = 5'd0;
      rs1[BODY_LEN + r - 1]  = 5'd1;
      rs2[BODY_LEN + r - 1]  = reg_addr_t'(r);
      imm[BODY_LEN + r - 1]  = 20'(DUMP_OFF + 4 * (r - 2));
    end
    for (int i = 0; i < PROG_LEN; i++) prog[i] = encode(kind[i], rd[i], rs1[i], rs2[i], imm[i]);
  endtask

  // sequential isa model, one instruction at a time
  task automatic run_model();
    word_t regs [32];
    word_t a, b, simm, r;
    foreach (regs[i]) regs[i] = '0;
    for (int i = 0; i < PROG_LEN; i++) begin
      a    = regs[rs1[i]];
      b    = regs[rs2[i]];
      simm = {{20{imm[i][11]}}, imm[i][11:0]};
      r    = '0;
      case (kind[i])
        K_LUI:  r = {imm[i], 12'h000};
        K_ADDI: r = a + simm;
        K_XORI: r = a ^ simm;
        K_ORI:  r = a | simm;
        K_ANDI: r = a & simm;
        K_SLTI: r = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
        K_ADD:  r = a + b;
        K_SUB:  r = a - b;
        K_XOR:  r = a ^ b;
        K_OR:   r = a | b;
        K_AND:  r = a & b;
        K_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        K_LW: begin
          exp_ld_addr.push_back(a + simm);
          r = model_read(a + simm);
        end
        default: begin
          exp_st_addr.push_back(a + simm);
          exp_st_data.push_back(b);
          model_mem[a + simm] = b;
        end
      endcase
      if (kind[i] != K_SW) regs[rd[i]] = r;
    end
    model_regs = regs;
  endtask

  task automatic compare_word(input int t, input string name, input word_t exp, input word_t got);
    checks[t]++;
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      errs[t]++;
    end
  endtask

  task automatic check_true(input int t, input logic cond, input string what);
    checks[t]++;
    assert (cond) else begin
      $display("Error at %0t: %s", $time, what);
      errs[t]++;
    end
  endtask

  task automatic report_test(input int t, input string name);
    $display("test %s: %0d checks, %0d errors", name, checks[t], errs[t]);
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout at %0t: no %s within the cycle limit", $time, what);
    timed_out = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction memory, random grant and rvalid delays
  //////////////////////////////////////////////////////////////////////
  int    igw = -1;            // grant delay left, -1 until drawn
  int    irw = 0;             // rvalid delay left
  word_t iaddr;
  word_t exp_fetch = BOOT_ADDR;

  always @(negedge clk) begin
    instr_rvalid = 1'b0;
    if (!rst_n) check_true(T_FETCH, !instr_req, "instruction request raised during reset");
    if (instr_gnt) begin      // taken on the edge just gone
      instr_gnt = 1'b0;
      irw = 1 + urand(3);
    end
    if (irw > 0) begin
      irw--;
      if (irw == 0) begin
        instr_rvalid = 1'b1;
        instr_rdata  = imem_read(iaddr);
      end
    end
    if (instr_req) begin
      if (igw < 0) igw = urand(4);
      if (igw == 0) begin
        instr_gnt = 1'b1;
        iaddr     = instr_addr;
        compare_word(T_FETCH, "instr_addr_o", exp_fetch, instr_addr);
        check_true(T_DONE, core_busy, "core_busy_o low during a fetch");
        exp_fetch += 4;       // straight-line fetch
        igw = -1;
      end else begin
        igw--;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data memory, same delays, checks at grant
  //////////////////////////////////////////////////////////////////////
  int    dgw = -1;
  int    drw = 0;
  logic  d_we;
  word_t d_addr;
  word_t d_wdata;

  always @(negedge clk) begin
    data_rvalid = 1'b0;
    if (!rst_n) check_true(T_STORE, !data_req, "data request raised during reset");
    if (data_gnt) begin
      data_gnt = 1'b0;
      drw = 1 + urand(3);
    end
    if (drw > 0) begin
      drw--;
      if (drw == 0) begin
        data_rvalid = 1'b1;
        if (d_we) dmem[d_addr] = d_wdata;
        data_rdata = d_we ? '0 : mem_read(d_addr);
      end
    end
    if (data_req) begin
      if (dgw < 0) dgw = urand(4);
      if (dgw == 0) begin
        data_gnt = 1'b1;
        d_we     = data_we;
        d_addr   = data_addr;
        d_wdata  = data_wdata;
        dgw      = -1;
        check_true(T_DONE, core_busy, "core_busy_o low during a data access");
        if (data_we) begin
          store_count++;
          if (exp_st_addr.size() == 0) begin
            check_true(T_STORE, 1'b0, "store issued after the last expected store");
          end else begin
            compare_word(T_STORE, "data_addr_o", exp_st_addr.pop_front(), data_addr);
            compare_word(T_STORE, "data_wdata_o", exp_st_data.pop_front(), data_wdata);
          end
        end else if (exp_ld_addr.size() == 0) begin
          check_true(T_LOAD, 1'b0, "load issued that the program does not hold");
        end else begin
          compare_word(T_LOAD, "data_addr_o", exp_ld_addr.pop_front(), data_addr);
        end
      end else begin
        dgw--;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    int cyc;
    int proto_fails;
    int total_checks;
    int total_errs;
    gen_program();
    run_model();
    n_stores = exp_st_addr.size();
    cyc = 0;
    while (!rst_n && !timed_out) begin
      @(posedge clk);
      cyc++;
      if (cyc > 20) note_timeout("reset release");
    end
    if (!timed_out) begin
      @(negedge clk);
      fetch_enable = 1'b1;
      cyc = 0;
      while (store_count < n_stores && !timed_out) begin
        @(posedge clk);
        cyc++;
        if (cyc > 4000) note_timeout("completion of all program stores");
      end
    end
    if (!timed_out) begin
      report_test(T_STORE, "store stream");
      check_true(T_LOAD, exp_ld_addr.size() == 0, "fewer loads issued than the program holds");
      report_test(T_LOAD, "load addresses");
      @(negedge clk);
      fetch_enable = 1'b0;
      cyc = 0;
      while (core_busy && !timed_out) begin
        @(negedge clk);       // busy moves on the rising edge
        cyc++;
        if (cyc > 100) note_timeout("fall of core_busy_o after fetch disable");
      end
    end
    if (!timed_out) begin
      check_true(T_DONE, !instr_req && !data_req, "request still raised with the core idle");
      report_test(T_DONE, "completion");
      report_test(T_FETCH, "fetch order");
      for (int r = 2; r < 32; r++) begin
        compare_word(T_REGS, $sformatf("dump of x%0d", r), model_regs[r],
                     mem_read(DATA_BASE + DUMP_OFF + 4 * (r - 2)));
      end
      report_test(T_REGS, "register dump");
    end
    proto_fails = u_riscv_core.core_assert_i.fail_count;
    if (proto_fails != 0) $display("Error: %0d protocol assertion failures", proto_fails);
    total_checks = 0;
    total_errs   = proto_fails;
    for (int t = 0; t < 5; t++) begin
      total_checks += checks[t];
      total_errs   += errs[t];
    end
    $display("total: %0d checks, %0d errors", total_checks, total_errs);
    if (total_errs == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
